/* source/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // ------------------------------------------------------------
    // Addresses
    // ------------------------------------------------------------
    localparam int ADDR_WIDTH = 32;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    localparam int FETCH_BLOCK_BYTES = 16;  // Aligned fetch granule

    // ------------------------------------------------------------
    // Target buffer
    // ------------------------------------------------------------
    localparam int BTB_DEPTH = 8;
    localparam int BTB_IDX = 3;
    typedef logic [BTB_IDX-1:0] btb_idx_t;

    // Branch and jump tables share one storage array
    localparam int NUM_TABLES = 2;
    localparam int TBL_BRANCH = 0;
    localparam int TBL_JUMP = 1;

    // ------------------------------------------------------------
    // Direction counters
    // ------------------------------------------------------------
    localparam int BHT_DEPTH = 64;
    localparam int BHT_IDX = 6;  // Indexed by pc[7:2]
    typedef logic [BHT_IDX-1:0] bht_idx_t;

    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_state_t;

    // ------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------
    localparam int CFG_ADDR_WIDTH = 2;
    typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

    localparam cfg_addr_t CFG_CTRL_ADDR = 2'd0;
    localparam cfg_addr_t CFG_COUNT_ADDR = 2'd1;

    // Control register fields
    localparam int CTRL_BTB_EN_BIT = 0;
    localparam int CTRL_FORCE_NT_BIT = 1;
    localparam int CTRL_FLUSH_BIT = 2;

    localparam int UPD_COUNT_WIDTH = 16;

endpackage

`default_nettype wire

/* source/bp_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_config_regs (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              cfg_wr_en,
    input  wire bp_pkg::cfg_addr_t cfg_addr,
    input  wire logic [31:0]       cfg_wdata,
    output logic [31:0]            cfg_rdata,

    input  wire logic              update_fire,

    output logic                   btb_enable,
    output logic                   force_not_taken,
    output logic                   flush
);

    logic                              wr_ctrl;
    logic                              wr_count;
    logic [bp_pkg::UPD_COUNT_WIDTH-1:0] upd_count;

    assign wr_ctrl  = cfg_wr_en && (cfg_addr == bp_pkg::CFG_CTRL_ADDR);
    assign wr_count = cfg_wr_en && (cfg_addr == bp_pkg::CFG_COUNT_ADDR);

    // ------------------------------------------------------------
    // Control bits
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            btb_enable      <= 1'b1;
            force_not_taken <= 1'b0;
            flush           <= 1'b0;
        end else begin
            // Flush only ever lasts one cycle
            flush <= wr_ctrl && cfg_wdata[bp_pkg::CTRL_FLUSH_BIT] && !flush;
            if (wr_ctrl) begin
                btb_enable      <= cfg_wdata[bp_pkg::CTRL_BTB_EN_BIT];
                force_not_taken <= cfg_wdata[bp_pkg::CTRL_FORCE_NT_BIT];
            end
        end
    end

    // Accepted commit update count
    always_ff @(posedge clk) begin
        if (rst || wr_count) begin
            upd_count <= '0;
        end else if (update_fire) begin
            upd_count <= upd_count + 1'b1;
        end
    end

    // Read-back
    always_comb begin
        cfg_rdata = '0;
        if (cfg_addr == bp_pkg::CFG_CTRL_ADDR) begin
            cfg_rdata[bp_pkg::CTRL_BTB_EN_BIT]   = btb_enable;
            cfg_rdata[bp_pkg::CTRL_FORCE_NT_BIT] = force_not_taken;
        end else if (cfg_addr == bp_pkg::CFG_COUNT_ADDR) begin
            cfg_rdata[bp_pkg::UPD_COUNT_WIDTH-1:0] = upd_count;
        end
    end

endmodule

`default_nettype wire

/* source/bimodal_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module bimodal_predictor (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          flush,
    input  wire logic          force_not_taken,

    input  wire bp_pkg::addr_t pc,
    output logic               dir_taken,

    input  wire logic          update_valid,
    output logic               update_ready,
    input  wire bp_pkg::addr_t update_pc,
    input  wire logic          update_taken,
    input  wire logic          update_is_jump
);

    bp_pkg::ctr_state_t bht [bp_pkg::BHT_DEPTH];

    logic               busy;
    bp_pkg::bht_idx_t   init_ptr;
    bp_pkg::bht_idx_t   sweep_idx;
    logic               initialising;

    logic               upd_fire;
    bp_pkg::bht_idx_t   upd_idx;
    bp_pkg::bht_idx_t   lk_idx;
    bp_pkg::ctr_state_t ctr_cur;
    bp_pkg::ctr_state_t ctr_next;

    // Flush cycle counts as the first sweep step
    assign initialising = busy || flush;
    assign sweep_idx    = flush ? '0 : init_ptr;
    assign update_ready = !initialising;

    assign upd_fire = update_valid && update_ready;
    assign upd_idx  = update_pc[bp_pkg::BHT_IDX+1:2];
    assign lk_idx   = pc[bp_pkg::BHT_IDX+1:2];

    // ------------------------------------------------------------
    // Init sweep control
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b1;
            init_ptr <= '0;
        end else if (initialising) begin
            init_ptr <= sweep_idx + 1'b1;
            busy     <= (sweep_idx != bp_pkg::bht_idx_t'(bp_pkg::BHT_DEPTH - 1));
        end
    end

    // Saturating step toward the outcome
    assign ctr_cur = bht[upd_idx];

    always_comb begin
        case (ctr_cur)
            bp_pkg::CTR_STRONG_NT:
                ctr_next = update_taken ? bp_pkg::CTR_WEAK_NT : bp_pkg::CTR_STRONG_NT;
            bp_pkg::CTR_WEAK_NT:
                ctr_next = update_taken ? bp_pkg::CTR_WEAK_T : bp_pkg::CTR_STRONG_NT;
            bp_pkg::CTR_WEAK_T:
                ctr_next = update_taken ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_NT;
            bp_pkg::CTR_STRONG_T:
                ctr_next = update_taken ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_T;
            default:
                ctr_next = bp_pkg::CTR_WEAK_NT;
        endcase
    end

    // Counter table
    always_ff @(posedge clk) begin
        if (initialising) begin
            bht[sweep_idx] <= bp_pkg::CTR_WEAK_NT;
        end else if (upd_fire && !update_is_jump) begin
            bht[upd_idx] <= ctr_next;
        end
    end

    // ------------------------------------------------------------
    // Prediction
    // ------------------------------------------------------------
    always_comb begin
        dir_taken = (bht[lk_idx] == bp_pkg::CTR_WEAK_T)
                 || (bht[lk_idx] == bp_pkg::CTR_STRONG_T);
        if (initialising || force_not_taken) begin
            dir_taken = 1'b0;  // Table not valid yet
        end
    end

endmodule

`default_nettype wire

/* source/btb.sv */
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          flush,
    input  wire logic          btb_enable,

    input  wire bp_pkg::addr_t pc,
    input  wire logic          dir_taken,
    output bp_pkg::addr_t      pred_target,
    output logic               pred_taken,

    input  wire logic          update_fire,
    input  wire bp_pkg::addr_t update_pc,
    input  wire bp_pkg::addr_t update_target,
    input  wire logic          update_taken,
    input  wire logic          update_is_jump
);

    // Table 0 holds conditional branches, table 1 jumps
    logic             valid [bp_pkg::NUM_TABLES][bp_pkg::BTB_DEPTH];
    bp_pkg::addr_t    tag_pc [bp_pkg::NUM_TABLES][bp_pkg::BTB_DEPTH];
    bp_pkg::addr_t    target [bp_pkg::NUM_TABLES][bp_pkg::BTB_DEPTH];
    bp_pkg::btb_idx_t rr_ptr [bp_pkg::NUM_TABLES];

    logic             upd_tbl;
    logic             upd_write;
    logic             upd_hit;
    logic             upd_free;
    bp_pkg::btb_idx_t upd_hit_idx;
    bp_pkg::btb_idx_t upd_free_idx;
    bp_pkg::btb_idx_t wr_idx;

    logic             lk_hit [bp_pkg::NUM_TABLES];
    bp_pkg::addr_t    lk_target [bp_pkg::NUM_TABLES];
    bp_pkg::addr_t    fall_through;

    assign upd_tbl = update_is_jump ? 1'(bp_pkg::TBL_JUMP) : 1'(bp_pkg::TBL_BRANCH);

    // Not-taken branches never enter the table
    assign upd_write = update_fire && (update_is_jump || update_taken);

    // ------------------------------------------------------------
    // Update slot search
    // ------------------------------------------------------------
    always_comb begin
        upd_hit      = 1'b0;
        upd_free     = 1'b0;
        upd_hit_idx  = '0;
        upd_free_idx = '0;
        for (int i = 0; i < bp_pkg::BTB_DEPTH; i++) begin
            if (valid[upd_tbl][i] && (tag_pc[upd_tbl][i] == update_pc)) begin
                upd_hit     = 1'b1;
                upd_hit_idx = bp_pkg::btb_idx_t'(i);
            end
            if (!valid[upd_tbl][i]) begin
                upd_free     = 1'b1;
                upd_free_idx = bp_pkg::btb_idx_t'(i);  // Highest invalid wins
            end
        end
    end

    always_comb begin
        if (upd_hit) begin
            wr_idx = upd_hit_idx;
        end else if (upd_free) begin
            wr_idx = upd_free_idx;
        end else begin
            wr_idx = rr_ptr[upd_tbl];
        end
    end

    // Valid bits and replacement pointers
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int t = 0; t < bp_pkg::NUM_TABLES; t++) begin
                rr_ptr[t] <= '0;
                for (int i = 0; i < bp_pkg::BTB_DEPTH; i++) begin
                    valid[t][i] <= 1'b0;
                end
            end
        end else if (upd_write) begin
            valid[upd_tbl][wr_idx] <= 1'b1;
            if (!upd_hit && !upd_free) begin
                rr_ptr[upd_tbl] <= rr_ptr[upd_tbl] + 1'b1;  // Wraps
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (upd_write) begin
            tag_pc[upd_tbl][wr_idx] <= update_pc;
            target[upd_tbl][wr_idx] <= update_target;
        end
    end

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    assign fall_through = (pc + bp_pkg::addr_t'(bp_pkg::FETCH_BLOCK_BYTES))
                        & ~bp_pkg::addr_t'(bp_pkg::FETCH_BLOCK_BYTES - 1);

    always_comb begin
        for (int t = 0; t < bp_pkg::NUM_TABLES; t++) begin
            lk_hit[t]    = 1'b0;
            lk_target[t] = '0;
            for (int i = 0; i < bp_pkg::BTB_DEPTH; i++) begin
                if (valid[t][i] && (tag_pc[t][i] == pc)) begin
                    lk_hit[t]    = 1'b1;
                    lk_target[t] = target[t][i];
                end
            end
        end
    end

    always_comb begin
        pred_target = fall_through;
        pred_taken  = 1'b0;
        if (btb_enable) begin
            if (lk_hit[bp_pkg::TBL_JUMP]) begin
                pred_target = lk_target[bp_pkg::TBL_JUMP];
                pred_taken  = 1'b1;
            end else if (lk_hit[bp_pkg::TBL_BRANCH] && dir_taken) begin
                pred_target = lk_target[bp_pkg::TBL_BRANCH];
                pred_taken  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/fetch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor (
    input  wire logic              clk,
    input  wire logic              rst,

    // Fetch
    input  wire bp_pkg::addr_t     pc,
    output logic                   pred_taken,
    output bp_pkg::addr_t          pred_target,

    // Commit
    input  wire logic              update_valid,
    output logic                   update_ready,
    input  wire bp_pkg::addr_t     update_pc,
    input  wire bp_pkg::addr_t     update_target,
    input  wire logic              update_taken,
    input  wire logic              update_is_jump,

    // Configuration
    input  wire logic              cfg_wr_en,
    input  wire bp_pkg::cfg_addr_t cfg_addr,
    input  wire logic [31:0]       cfg_wdata,
    output logic [31:0]            cfg_rdata
);

    logic btb_enable;
    logic force_not_taken;
    logic flush;
    logic dir_taken;
    logic update_fire;

    assign update_fire = update_valid && update_ready;  // Accepted transfer

    bp_config_regs bp_config_regs_inst (
        .clk             (clk),
        .rst             (rst),
        .cfg_wr_en       (cfg_wr_en),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg_rdata       (cfg_rdata),
        .update_fire     (update_fire),
        .btb_enable      (btb_enable),
        .force_not_taken (force_not_taken),
        .flush           (flush)
    );

    bimodal_predictor bimodal_predictor_inst (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .force_not_taken (force_not_taken),
        .pc              (pc),
        .dir_taken       (dir_taken),
        .update_valid    (update_valid),
        .update_ready    (update_ready),
        .update_pc       (update_pc),
        .update_taken    (update_taken),
        .update_is_jump  (update_is_jump)
    );

    btb btb_inst (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .btb_enable     (btb_enable),
        .pc             (pc),
        .dir_taken      (dir_taken),
        .pred_target    (pred_target),
        .pred_taken     (pred_taken),
        .update_fire    (update_fire),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .update_taken   (update_taken),
        .update_is_jump (update_is_jump)
    );

endmodule

`default_nettype wire

/* test/fetch_predictor_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor_assertions (
    input wire logic clk,
    input wire logic rst,
    input wire logic update_ready,
    input wire logic flush,
    input wire logic btb_enable,
    input wire logic pred_taken
);

    int fail_count = 0;

    // Init sweep starts straight out of reset
    ready_low_after_reset: assert property (@(posedge clk) rst |=> !update_ready)
        else begin
            fail_count++;
            $error("update_ready high in the cycle after reset");
        end

    flush_single_cycle: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
        else begin
            fail_count++;
            $error("flush pulse lasted two cycles");
        end

    no_taken_when_disabled: assert property (
        @(posedge clk) disable iff (rst) !btb_enable |-> !pred_taken)
        else begin
            fail_count++;
            $error("pred_taken high with the BTB disabled");
        end

endmodule

bind fetch_predictor fetch_predictor_assertions fetch_predictor_assertions_inst (
    .clk          (clk),
    .rst          (rst),
    .update_ready (update_ready),
    .flush        (flush),
    .btb_enable   (btb_enable),
    .pred_taken   (pred_taken)
);

`default_nettype wire

/* test/tb_fetch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_predictor;

    localparam int RESET_CYCLES = 5;
    localparam int JUMP_ROUNDS = 40;
    localparam int BRANCH_ROUNDS = 60;
    localparam int JUMP_POOL = 16;    // Exceeds BTB_DEPTH to force replacement
    localparam int BRANCH_POOL = 8;
    localparam bp_pkg::addr_t JUMP_BASE = 32'h0000_2000;
    localparam bp_pkg::addr_t BRANCH_BASE = 32'h0000_2100;
    localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + 2 * bp_pkg::BHT_DEPTH
        + 2 * (JUMP_ROUNDS + BRANCH_ROUNDS) + 4 * (JUMP_POOL + BRANCH_POOL) + 40);

    logic              clk;
    logic              rst;
    bp_pkg::addr_t     pc;
    logic              pred_taken;
    bp_pkg::addr_t     pred_target;
    logic              update_valid;
    logic              update_ready;
    bp_pkg::addr_t     update_pc;
    bp_pkg::addr_t     update_target;
    logic              update_taken;
    logic              update_is_jump;
    logic              cfg_wr_en;
    bp_pkg::cfg_addr_t cfg_addr;
    logic [31:0]       cfg_wdata;
    logic [31:0]       cfg_rdata;

    // Reference model state
    logic          mdl_valid [2][bp_pkg::BTB_DEPTH];
    bp_pkg::addr_t mdl_tag [2][bp_pkg::BTB_DEPTH];
    bp_pkg::addr_t mdl_tgt [2][bp_pkg::BTB_DEPTH];
    int            mdl_rr [2];
    int            mdl_ctr [bp_pkg::BHT_DEPTH];  // 0 strong NT .. 3 strong T
    logic          mdl_en;
    logic          mdl_fnt;
    logic [bp_pkg::UPD_COUNT_WIDTH-1:0] mdl_count;

    logic [31:0] rng_state = 32'hcdb9;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    fetch_predictor fetch_predictor_inst (
        .clk            (clk),
        .rst            (rst),
        .pc             (pc),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .update_valid   (update_valid),
        .update_ready   (update_ready),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .update_taken   (update_taken),
        .update_is_jump (update_is_jump),
        .cfg_wr_en      (cfg_wr_en),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %-14s %0d checks, %0d errors", name, test_checks, test_errors);
        checks += test_checks;
        errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Start of the next 16-byte block
    function automatic bp_pkg::addr_t block_after(input bp_pkg::addr_t a);
        return (a & ~32'hf) + 32'h10;
    endfunction

    task automatic table_insert(input int t, input bp_pkg::addr_t a, input bp_pkg::addr_t tg);
        int slot;
        slot = -1;
        for (int i = 0; i < bp_pkg::BTB_DEPTH; i++) begin
            if (mdl_valid[t][i] && mdl_tag[t][i] == a) slot = i;
        end
        if (slot < 0) begin
            for (int i = 0; i < bp_pkg::BTB_DEPTH; i++) begin
                if (!mdl_valid[t][i]) slot = i;  // Highest free slot
            end
        end
        if (slot < 0) begin
            slot = mdl_rr[t];
            mdl_rr[t] = (mdl_rr[t] + 1) % bp_pkg::BTB_DEPTH;
        end
        mdl_valid[t][slot] = 1'b1;
        mdl_tag[t][slot] = a;
        mdl_tgt[t][slot] = tg;
    endtask

    task automatic apply_commit(input bp_pkg::addr_t a, input bp_pkg::addr_t tg,
                                input logic taken, input logic jump);
        int idx;
        idx = a[7:2];
        mdl_count++;
        if (jump) begin
            table_insert(bp_pkg::TBL_JUMP, a, tg);
        end else begin
            if (taken && mdl_ctr[idx] < 3) mdl_ctr[idx]++;
            else if (!taken && mdl_ctr[idx] > 0) mdl_ctr[idx]--;
            if (taken) table_insert(bp_pkg::TBL_BRANCH, a, tg);
        end
    endtask

    task automatic clear_tables();
        for (int t = 0; t < 2; t++) begin
            mdl_rr[t] = 0;
            for (int i = 0; i < bp_pkg::BTB_DEPTH; i++) mdl_valid[t][i] = 1'b0;
        end
        for (int i = 0; i < bp_pkg::BHT_DEPTH; i++) mdl_ctr[i] = 1;  // Weak not-taken
    endtask

    task automatic expected_prediction(input bp_pkg::addr_t a, output bp_pkg::addr_t tgt,
                                       output logic taken);
        logic          jump_hit;
        logic          branch_hit;
        bp_pkg::addr_t jump_tgt;
        bp_pkg::addr_t branch_tgt;
        logic          dir;
        jump_hit = 1'b0;
        branch_hit = 1'b0;
        jump_tgt = '0;
        branch_tgt = '0;
        for (int i = 0; i < bp_pkg::BTB_DEPTH; i++) begin
            if (mdl_valid[bp_pkg::TBL_JUMP][i] && mdl_tag[bp_pkg::TBL_JUMP][i] == a) begin
                jump_hit = 1'b1;
                jump_tgt = mdl_tgt[bp_pkg::TBL_JUMP][i];
            end
            if (mdl_valid[bp_pkg::TBL_BRANCH][i] && mdl_tag[bp_pkg::TBL_BRANCH][i] == a) begin
                branch_hit = 1'b1;
                branch_tgt = mdl_tgt[bp_pkg::TBL_BRANCH][i];
            end
        end
        dir = (mdl_ctr[a[7:2]] >= 2) && !mdl_fnt;
        tgt = block_after(a);
        taken = 1'b0;
        if (mdl_en && jump_hit) begin
            tgt = jump_tgt;
            taken = 1'b1;
        end else if (mdl_en && branch_hit && dir) begin
            tgt = branch_tgt;
            taken = 1'b1;
        end
    endtask

    task automatic probe_pc(input string name, input bp_pkg::addr_t a);
        bp_pkg::addr_t exp_tgt;
        logic          exp_taken;
        pc = a;
        #1;
        expected_prediction(a, exp_tgt, exp_taken);
        compare({name, " pred_taken"}, 32'(exp_taken), 32'(pred_taken));
        compare({name, " pred_target"}, exp_tgt, pred_target);
        @(posedge clk);
        #1;
    endtask

    // Holds the fields until accepted and returns the stalled cycles
    task automatic send_update(input bp_pkg::addr_t a, input bp_pkg::addr_t tg,
                               input logic taken, input logic jump, output int waited);
        logic accepted;
        update_valid = 1'b1;
        update_pc = a;
        update_target = tg;
        update_taken = taken;
        update_is_jump = jump;
        waited = 0;
        accepted = 1'b0;
        while (!accepted) begin
            #1;
            accepted = update_ready;
            @(posedge clk);
            #1;
            if (!accepted) waited++;
        end
        update_valid = 1'b0;
        apply_commit(a, tg, taken, jump);
    endtask

    task automatic write_config(input bp_pkg::cfg_addr_t addr, input logic [31:0] data);
        cfg_wr_en = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_wr_en = 1'b0;
        if (addr == bp_pkg::CFG_CTRL_ADDR) begin
            mdl_en = data[0];
            mdl_fnt = data[1];
            if (data[2]) clear_tables();
        end else if (addr == bp_pkg::CFG_COUNT_ADDR) begin
            mdl_count = '0;
        end
    endtask

    task automatic read_back(input string name, input bp_pkg::cfg_addr_t addr);
        logic [31:0] expected;
        cfg_addr = addr;
        #1;
        if (addr == bp_pkg::CFG_CTRL_ADDR) expected = {30'b0, mdl_fnt, mdl_en};
        else expected = 32'(mdl_count);
        compare(name, expected, cfg_rdata);
        @(posedge clk);
        #1;
    endtask

    task automatic scan_pools(input string name);
        for (int k = 0; k < JUMP_POOL; k++) probe_pc(name, JUMP_BASE + 32'(k * 4));
        for (int k = 0; k < BRANCH_POOL; k++) probe_pc(name, BRANCH_BASE + 32'(k * 4));
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0]   r;
        bp_pkg::addr_t a;
        int            waited;
        int            low_cycles;
        logic          ready_seen;
        int            assert_fails;
        rst = 1'b1;
        pc = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_target = '0;
        update_taken = 1'b0;
        update_is_jump = 1'b0;
        cfg_wr_en = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        mdl_en = 1'b1;
        mdl_fnt = 1'b0;
        mdl_count = '0;
        clear_tables();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset and init sweep
        low_cycles = 0;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            #1;
            ready_seen = update_ready;
            if (!ready_seen) low_cycles++;
            @(posedge clk);
            #1;
        end
        compare("reset_init ready_low", bp_pkg::BHT_DEPTH, low_cycles);
        read_back("reset_init ctrl", bp_pkg::CFG_CTRL_ADDR);
        read_back("reset_init count", bp_pkg::CFG_COUNT_ADDR);
        finish_test("reset_init");

        repeat (JUMP_ROUNDS) begin
            r = next_rand();
            a = JUMP_BASE + 32'((r % JUMP_POOL) * 4);
            send_update(a, next_rand() & 32'hffff_fffc, r[31], 1'b1, waited);
            compare("jump_learning stall", 0, waited);
            r = next_rand();
            probe_pc("jump_learning", JUMP_BASE + 32'((r % JUMP_POOL) * 4));
        end
        scan_pools("jump_learning");
        finish_test("jump_learning");

        // Odd pcs lean taken and even pcs lean not-taken
        repeat (BRANCH_ROUNDS) begin
            r = next_rand();
            a = BRANCH_BASE + 32'((r % BRANCH_POOL) * 4);
            send_update(a, next_rand() & 32'hffff_fffc,
                        a[2] ? (r[9:8] != 2'b00) : (r[9:8] == 2'b00), 1'b0, waited);
            r = next_rand();
            probe_pc("branch_dir", BRANCH_BASE + 32'((r % BRANCH_POOL) * 4));
        end
        scan_pools("branch_dir");
        read_back("branch_dir count", bp_pkg::CFG_COUNT_ADDR);
        finish_test("branch_dir");

        write_config(bp_pkg::CFG_CTRL_ADDR, 32'h3);
        read_back("config force_nt", bp_pkg::CFG_CTRL_ADDR);
        scan_pools("config force_nt");
        write_config(bp_pkg::CFG_CTRL_ADDR, 32'h0);
        read_back("config disabled", bp_pkg::CFG_CTRL_ADDR);
        scan_pools("config disabled");
        write_config(bp_pkg::CFG_CTRL_ADDR, 32'h1);
        finish_test("config");

        // Flush with one update held through the sweep
        write_config(bp_pkg::CFG_COUNT_ADDR, 32'h0);
        write_config(bp_pkg::CFG_CTRL_ADDR, 32'h5);
        send_update(JUMP_BASE, 32'h0000_8000, 1'b1, 1'b1, waited);
        compare("flush stall", bp_pkg::BHT_DEPTH, waited);
        send_update(BRANCH_BASE, 32'h0000_9000, 1'b1, 1'b0, waited);
        compare("flush stall after", 0, waited);
        read_back("flush count", bp_pkg::CFG_COUNT_ADDR);
        read_back("flush ctrl", bp_pkg::CFG_CTRL_ADDR);
        scan_pools("flush");
        finish_test("flush");

        assert_fails = fetch_predictor_inst.fetch_predictor_assertions_inst.fail_count;
        if (assert_fails != 0) begin
            $display("Bound assertions failed %0d times", assert_fails);
            errors += assert_fails;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/bp_pkg.sv
source/bp_config_regs.sv
source/bimodal_predictor.sv
source/btb.sv
source/fetch_predictor.sv
test/fetch_predictor_assertions.sv
test/tb_fetch_predictor.sv

/* Bender.yml */
package:
  name: fetch_predictor

sources:
  # Design, in compile order
  - files:
      - source/bp_pkg.sv
      - source/bp_config_regs.sv
      - source/bimodal_predictor.sv
      - source/btb.sv
      - source/fetch_predictor.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/fetch_predictor_assertions.sv
      - test/tb_fetch_predictor.sv
